/* dispatch_pkg.sv */
// ==========================================================================
// dispatch package
// slot bundle and grant types shared by the queue count logic and the
// issue queue and reorder buffer rings, plus index width and wraparound
// helpers for the ring pointers
// ==========================================================================

package dispatch_pkg;

        // a fetch bundle always carries three slots, the grant decision
        // tree in queue_count is written for exactly this many
        localparam int unsigned num_slots = 3;

        // count of slots granted in one cycle, 0 to 3
        typedef logic [1:0] cnt_t;

        // one fetch bundle as seen by dispatch
        // bit n of every mask refers to bundle position n
        typedef struct packed {
                logic [num_slots-1:0] vd;
                logic [num_slots-1:0] jc;
                logic [num_slots-1:0] ret;
                logic [num_slots-1:0] take_branch;
        } slot_bundle_t;

        // the dispatch decision handed back to fetch
        // cnt is the number of slots that entered both queues and onp marks
        // the bundle positions they came from
        typedef struct packed {
                cnt_t                 cnt;
                logic [num_slots-1:0] onp;
        } queue_grant_t;

        // ==================================================================
        // width helpers
        // ==================================================================

        // index width of a ring with the given depth
        // a single-entry ring still gets a one-bit pointer
        function automatic int unsigned idx_bits(int unsigned depth);
                return (depth > 1) ? $clog2(depth) : 1;
        endfunction

        // base plus step modulo depth
        // base is always below depth and step never exceeds num_slots,
        // so one conditional subtract covers every ring of three or more
        // entries without a divider
        function automatic int unsigned wrap_idx(int unsigned base,
                                                 int unsigned step,
                                                 int unsigned depth);
                int unsigned sum;
                sum = base + step;
                if (sum >= depth) begin
                        sum = sum - depth;
                end
                return sum;
        endfunction

endpackage

/* queue_count.sv */
// ==========================================================================
// queue count
// decides how many slots of the current fetch bundle enter the issue queue
// and the reorder buffer this cycle and which bundle positions they are
// ==========================================================================

module queue_count import dispatch_pkg::*; #(
        parameter int unsigned qentries = 8,
        parameter int unsigned rentries = 16,
        parameter int unsigned ways     = 3
) (
        input  logic                          branchmiss,
        input  logic                          debug_on,
        input  slot_bundle_t                  bundle,
        input  logic [qentries-1:0]           iq_v,
        input  logic [idx_bits(qentries)-1:0] iq_tail,
        input  logic [rentries-1:0]           rob_v,
        input  logic [idx_bits(rentries)-1:0] rob_tail,
        output queue_grant_t                  grant
);

        localparam int unsigned qw = idx_bits(qentries);
        localparam int unsigned rw = idx_bits(rentries);

        // ring indices the k-th granted slot would land on
        logic [qw-1:0]        iq_idx  [num_slots];
        logic [rw-1:0]        rob_idx [num_slots];

        // free[k] says both rings can take one more entry at tail+k
        logic [num_slots-1:0] free;

        // any flow change in a slot ends the group after that slot
        logic [num_slots-1:0] stop;

        // bundle position of the k-th valid slot and the number of valid slots
        logic [1:0]           pos [num_slots];
        cnt_t                 nvalid;

        // ==================================================================
        // free entries at tail, tail+1 and tail+2
        // ==================================================================

        always_comb begin
                for (int k = 0; k < num_slots; k++) begin
                        iq_idx[k]  = qw'(wrap_idx(iq_tail, k, qentries));
                        rob_idx[k] = rw'(wrap_idx(rob_tail, k, rentries));
                        free[k]    = !iq_v[iq_idx[k]] && !rob_v[rob_idx[k]];
                end
        end

        assign stop = bundle.jc | bundle.ret | bundle.take_branch;

        // ==================================================================
        // bundle mask decode
        // ==================================================================

        // valid slots are packed from the lowest position upward
        // 101 leaves a hole in the middle of the bundle and is treated as
        // illegal, the same as an empty bundle
        always_comb begin
                nvalid = 2'd0;
                pos[0] = 2'd0;
                pos[1] = 2'd0;
                pos[2] = 2'd0;
                case (bundle.vd)
                3'b001: begin
                        nvalid = 2'd1;
                        pos[0] = 2'd0;
                end
                3'b010: begin
                        nvalid = 2'd1;
                        pos[0] = 2'd1;
                end
                3'b100: begin
                        nvalid = 2'd1;
                        pos[0] = 2'd2;
                end
                3'b011: begin
                        nvalid = 2'd2;
                        pos[0] = 2'd0;
                        pos[1] = 2'd1;
                end
                3'b110: begin
                        nvalid = 2'd2;
                        pos[0] = 2'd1;
                        pos[1] = 2'd2;
                end
                3'b111: begin
                        nvalid = 2'd3;
                        pos[0] = 2'd0;
                        pos[1] = 2'd1;
                        pos[2] = 2'd2;
                end
                default: ;
                endcase
        end

        // ==================================================================
        // grant walk
        // ==================================================================

        // each valid slot in turn queues while the chain is unbroken
        // a slot after the first also needs debug off and enough ways
        always_comb begin
                logic go;
                grant = '0;
                go    = 1'b1;
                if (!branchmiss) begin
                        for (int k = 0; k < num_slots; k++) begin
                                if (go && k < nvalid && free[k] &&
                                    (k == 0 || (!debug_on && ways > k))) begin
                                        grant.cnt = cnt_t'(k + 1);
                                        grant.onp[pos[k]] = 1'b1;
                                        // a jump, return or taken branch ends the group
                                        go = !stop[pos[k]];
                                end else begin
                                        go = 1'b0;
                                end
                        end
                end
        end

endmodule

/* entry_ring.sv */
// ==========================================================================
// entry ring
// ring of valid bits with an in-order tail that allocates up to three
// entries per cycle and an in-order head that frees one entry per pulse
// ==========================================================================

module entry_ring import dispatch_pkg::*; #(
        parameter int unsigned depth = 8
) (
        input  logic                       clk,
        input  logic                       rst_n,
        input  cnt_t                       alloc_cnt,
        input  logic                       head_release,
        output logic [depth-1:0]           valid,
        output logic [idx_bits(depth)-1:0] tail
);

        localparam int unsigned iw = idx_bits(depth);

        // oldest entry, the next one to be freed
        logic [iw-1:0]    head;

        // entries set and cleared on the coming edge
        logic [depth-1:0] alloc_mask;
        logic [depth-1:0] rel_mask;

        // a release pulse only counts while something is held
        logic             do_release;

        assign do_release = head_release && (|valid);

        // ==================================================================
        // next-state masks
        // ==================================================================

        // alloc_cnt entries starting at tail, wrapping past the last one
        always_comb begin
                alloc_mask = '0;
                for (int k = 0; k < num_slots; k++) begin
                        if (k < alloc_cnt) begin
                                alloc_mask[wrap_idx(tail, k, depth)] = 1'b1;
                        end
                end
        end

        // the head entry is the only one ever released
        always_comb begin
                rel_mask = '0;
                if (do_release) begin
                        rel_mask[head] = 1'b1;
                end
        end

        // ==================================================================
        // state update
        // ==================================================================

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        valid <= '0;
                        head  <= '0;
                        tail  <= '0;
                end else begin
                        // release and allocation can land in the same cycle,
                        // grant never allocates onto the head it just saw valid
                        valid <= (valid & ~rel_mask) | alloc_mask;
                        tail  <= iw'(wrap_idx(tail, alloc_cnt, depth));
                        if (do_release) begin
                                head <= iw'(wrap_idx(head, 1, depth));
                        end
                end
        end

        // ==================================================================
        // checks
        // ==================================================================

        // queue_count must only grant onto free entries of this ring
        alloc_on_free: assert property (
                @(posedge clk) disable iff (!rst_n)
                (alloc_mask & valid) == '0
        ) else $error("allocation onto an entry that is still valid");

        // the grant can never ask for more entries than the ring has left
        alloc_fits: assert property (
                @(posedge clk) disable iff (!rst_n)
                int'(alloc_cnt) <= int'(depth) - $countones(valid)
        ) else $error("allocation count exceeds free entries");

endmodule

/* dispatch_top.sv */
// ==========================================================================
// dispatch top
// joins the queue count decision to the issue queue and reorder buffer
// rings, grant goes back to fetch and its count allocates in both rings
// ==========================================================================

module dispatch_top import dispatch_pkg::*; #(
        parameter int unsigned qentries = 8,
        parameter int unsigned rentries = 16,
        parameter int unsigned ways     = 3
) (
        input  logic                          clk,
        input  logic                          rst_n,
        input  logic                          branchmiss,
        input  logic                          debug_on,
        input  slot_bundle_t                  bundle,
        input  logic                          iq_release,
        input  logic                          rob_release,
        output queue_grant_t                  grant,
        output logic [idx_bits(qentries)-1:0] iq_tail,
        output logic [idx_bits(rentries)-1:0] rob_tail
);

        // occupancy of both rings as seen by the grant logic
        logic [qentries-1:0] iq_valid;
        logic [rentries-1:0] rob_valid;

        // ==================================================================
        // grant decision
        // ==================================================================

        // purely combinational, grant follows the bundle in the same cycle
        queue_count #(
                .qentries (qentries),
                .rentries (rentries),
                .ways     (ways)
        ) i_queue_count (
                .branchmiss (branchmiss),
                .debug_on   (debug_on),
                .bundle     (bundle),
                .iq_v       (iq_valid),
                .iq_tail    (iq_tail),
                .rob_v      (rob_valid),
                .rob_tail   (rob_tail),
                .grant      (grant)
        );

        // ==================================================================
        // rings
        // ==================================================================

        // both rings allocate the same count on the next edge, so their
        // tails move in step while the heads drain independently
        entry_ring #(
                .depth (qentries)
        ) i_iq_ring (
                .clk          (clk),
                .rst_n        (rst_n),
                .alloc_cnt    (grant.cnt),
                .head_release (iq_release),
                .valid        (iq_valid),
                .tail         (iq_tail)
        );

        entry_ring #(
                .depth (rentries)
        ) i_rob_ring (
                .clk          (clk),
                .rst_n        (rst_n),
                .alloc_cnt    (grant.cnt),
                .head_release (rob_release),
                .valid        (rob_valid),
                .tail         (rob_tail)
        );

endmodule

/* tb_dispatch.sv */
// ==========================================================================
// dispatch testbench
// replays the vector file against the dispatch top level, checks grant
// against the expected fields and tracks both ring tails in a model
// ==========================================================================

module tb_dispatch import dispatch_pkg::*;;

        timeunit 1ns;
        timeprecision 1ps;

        localparam int unsigned qentries   = 8;
        localparam int unsigned rentries   = 16;
        localparam int unsigned clk_period = 8;
        localparam int unsigned max_vec    = 64;

        logic                          clk = 1'b0;
        logic                          rst_n;
        logic                          branchmiss;
        logic                          debug_on;
        slot_bundle_t                  bundle;
        logic                          iq_release;
        logic                          rob_release;
        queue_grant_t                  grant;
        logic [idx_bits(qentries)-1:0] iq_tail;
        logic [idx_bits(rentries)-1:0] rob_tail;

        // one vector per entry, ten hex digits as laid out in the data file
        // entries past the end of the file stay unknown
        logic [39:0] vec_mem [0:max_vec-1];
        int unsigned num_vec;
        int unsigned errors;
        bit          loaded;

        // occupancy and tail of both rings as the rules predict them
        int unsigned iq_occ;
        int unsigned iq_tail_model;
        int unsigned rob_occ;
        int unsigned rob_tail_model;

        always #(clk_period / 2) clk = ~clk;

        dispatch_top i_dut (
                .clk         (clk),
                .rst_n       (rst_n),
                .branchmiss  (branchmiss),
                .debug_on    (debug_on),
                .bundle      (bundle),
                .iq_release  (iq_release),
                .rob_release (rob_release),
                .grant       (grant),
                .iq_tail     (iq_tail),
                .rob_tail    (rob_tail)
        );

        // ==================================================================
        // helpers
        // ==================================================================

        // digits from the top: bm dbg vd jc ret tb iq_rel rob_rel cnt onp
        task automatic drive_vector(input logic [39:0] v);
                branchmiss         = v[36];
                debug_on           = v[32];
                bundle.vd          = v[30:28];
                bundle.jc          = v[26:24];
                bundle.ret         = v[22:20];
                bundle.take_branch = v[18:16];
                iq_release         = v[12];
                rob_release        = v[8];
        endtask

        task automatic check_grant(input int unsigned idx, input logic [1:0] exp_cnt,
                                   input logic [2:0] exp_onp);
                if (grant.cnt !== exp_cnt || grant.onp !== exp_onp) begin
                        errors++;
                        $display("error %0t: vector %0d grant cnt %0d onp %b, expected %0d %b",
                                 $time, idx, grant.cnt, grant.onp, exp_cnt, exp_onp);
                end
        endtask

        // a release only frees something when the ring held an entry before
        // the edge, the granted entries then land at the old tail
        task automatic advance_model(input int unsigned cnt, input logic iq_rel,
                                     input logic rob_rel);
                if (iq_rel && iq_occ > 0) begin
                        iq_occ--;
                end
                if (rob_rel && rob_occ > 0) begin
                        rob_occ--;
                end
                iq_occ         = iq_occ + cnt;
                rob_occ        = rob_occ + cnt;
                iq_tail_model  = (iq_tail_model + cnt) % qentries;
                rob_tail_model = (rob_tail_model + cnt) % rentries;
                if (iq_occ > qentries || rob_occ > rentries) begin
                        errors++;
                        $display("the vector file grants more entries than a ring can hold");
                end
        endtask

        task automatic check_tails(input int unsigned idx);
                if ($isunknown(iq_tail) || int'(iq_tail) != iq_tail_model) begin
                        errors++;
                        $display("error %0t: after vector %0d iq_tail %0d, expected %0d",
                                 $time, idx, iq_tail, iq_tail_model);
                end
                if ($isunknown(rob_tail) || int'(rob_tail) != rob_tail_model) begin
                        errors++;
                        $display("error %0t: after vector %0d rob_tail %0d, expected %0d",
                                 $time, idx, rob_tail, rob_tail_model);
                end
        endtask

        // ==================================================================
        // watchdog
        // ==================================================================

        // ten spare cycles cover reset and the final tail check
        initial begin
                wait (loaded);
                #((num_vec + 10) * clk_period);
                $display("the run timed out before all vectors were applied");
                $display("Checks failed");
                $finish;
        end

        // ==================================================================
        // main sequence
        // ==================================================================

        initial begin
                logic [39:0] v;
                rst_n          = 1'b0;
                branchmiss     = 1'b0;
                debug_on       = 1'b0;
                bundle         = '0;
                iq_release     = 1'b0;
                rob_release    = 1'b0;
                errors         = 0;
                iq_occ         = 0;
                iq_tail_model  = 0;
                rob_occ        = 0;
                rob_tail_model = 0;

                $readmemh("dispatch_testdata.txt", vec_mem);
                num_vec = 0;
                while (num_vec < max_vec && !$isunknown(vec_mem[num_vec])) begin
                        num_vec++;
                end
                if (num_vec == 0) begin
                        errors++;
                        $display("no vectors could be read from dispatch_testdata.txt");
                end
                loaded = 1'b1;

                repeat (2) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
                // both tails start at zero after reset
                check_tails(0);

                for (int unsigned i = 0; i < num_vec; i++) begin
                        v = vec_mem[i];
                        drive_vector(v);
                        // grant is combinational and settles well before the edge
                        #2;
                        check_grant(i, v[5:4], v[2:0]);
                        advance_model(v[5:4], v[12], v[8]);
                        @(negedge clk);
                        check_tails(i);
                end

                bundle      = '0;
                iq_release  = 1'b0;
                rob_release = 1'b0;
                $display("%0d errors in %0d vectors", errors, num_vec);
                if (errors == 0) begin
                        $display("All checks passed");
                end else begin
                        $display("Checks failed");
                end
                $finish;
        end

endmodule

/* dispatch_testdata.txt */
// one vector per line as ten hex digits, bundle masks use bit n for slot n
// bm dbg vd jc ret tb iq_rel rob_rel exp_cnt exp_onp
// reset state, empty bundle, illegal mask 101, release into empty rings
0000000000
0050000000
0000001100
// single slots, then three wide with the issue queue tail wrapping
0010000011
0020000012
0040000014
0070001137
0070001137
// drain both rings
0000001100
0000001100
0000001100
0000001100
// flow change stops, the flag on the last slot stops nothing
0070011111
0060201112
0072001123
0070041137
// branch miss, then debug on
1070001100
1010001100
0170001111
0160001112
0130000011
// issue queue fills without releases, then releases resume grants
0030000023
0070000011
0070000000
0070001000
0070001011
0070001011
0000001000
0000001000
0000001000
0000001000
0000001000
// reorder buffer becomes the fuller ring
0030001023
0070001037
0070001011
0070001000
0070000100
0070000111
0070001111

/* dispatch.f */
dispatch_pkg.sv
queue_count.sv
entry_ring.sv
dispatch_top.sv
tb_dispatch.sv

/* Bender.yml */
package:
  name: dispatch

sources:
  # package first, then leaf modules, then the top level
  - dispatch_pkg.sv
  - queue_count.sv
  - entry_ring.sv
  - dispatch_top.sv

  # testbench, reads dispatch_testdata.txt from the project root
  - target: test
    files:
      - tb_dispatch.sv
